/* verilog/vrf_cfg_pkg.sv */
package vrf_cfg_pkg;

    // register file geometry
    localparam int VLEN         = 512;                  // bits per vector register
    localparam int DATA_WIDTH   = 64;                   // bits per bank word
    localparam int NUM_VREGS    = 32;                   // architectural vector registers

    // one register is split into this many bank words
    localparam int OFFS_PER_REG = VLEN / DATA_WIDTH;    // 8 words

    // address widths
    localparam int VREG_ADDR_W  = $clog2(NUM_VREGS);    // 5 bits
    localparam int OFF_W        = $clog2(OFFS_PER_REG); // 3 bits
    localparam int GRP_W        = 3;                    // index in a group, up to 8 regs

    // flat bank, register address on top and word offset below
    localparam int BANK_WORDS   = NUM_VREGS * OFFS_PER_REG;
    localparam int BANK_IDX_W   = VREG_ADDR_W + OFF_W;

    // register address, wraps modulo NUM_VREGS
    typedef logic [VREG_ADDR_W-1:0] vreg_addr_t;

    // word offset within one register
    typedef logic [OFF_W-1:0]       vreg_off_t;

    // register index within a group
    typedef logic [GRP_W-1:0]       grp_idx_t;

    typedef logic [DATA_WIDTH-1:0]  vdata_t;    // one bank word

    // {addr, off} word index into the bank
    typedef logic [BANK_IDX_W-1:0]  bank_idx_t;

endpackage

/* verilog/agu_pkg.sv */
package agu_pkg;

    // address generator FSM
    // idle waits for a start strobe, busy walks the latched group
    typedef enum logic {
        AGU_IDLE = 1'b0,   // no walk running, a start is taken at once
        AGU_BUSY = 1'b1    // registers hold the next beat to present
    } agu_state_t;

    // log2 of the register group size
    localparam int LMUL_W = 2;

    // only used in whole-register mode
    // 0 -> 1 reg, 1 -> 2 regs, 2 -> 4 regs, 3 -> 8 regs
    typedef logic [LMUL_W-1:0] lmul_code_t;

endpackage

/* verilog/addr_gen_unit.sv */
`timescale 1ns/1ps

// walks one register group, one beat per cycle
module addr_gen_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    en,         // start strobe
    input  logic                    whole_reg,  // group from lmul, all offsets
    input  logic                    widen,      // two beats per element
    input  agu_pkg::lmul_code_t     lmul,
    input  vrf_cfg_pkg::vreg_addr_t base_in,    // first register of the group
    input  vrf_cfg_pkg::grp_idx_t   max_reg_in, // last register index in the group
    input  vrf_cfg_pkg::vreg_off_t  max_off_in, // last offset in a register
    output vrf_cfg_pkg::vreg_addr_t addr,
    output vrf_cfg_pkg::vreg_off_t  off,
    output logic                    beat,
    output logic                    first_turn,
    output logic                    start_pulse,
    output logic                    end_pulse,
    output logic                    idle        // may issue another walk
);

    agu_pkg::agu_state_t     state;
    vrf_cfg_pkg::vreg_addr_t base_q;
    vrf_cfg_pkg::grp_idx_t   reg_q, max_reg_q;  // reg_q is the next beat's index
    vrf_cfg_pkg::vreg_off_t  off_q, max_off_q;
    logic                    widen_q;
    logic                    turn_q;            // second presentation of an element
    logic                    restart_q;         // walk relaunched on the last end beat

    logic                    busy;
    logic                    launch;            // start taken from idle
    logic                    restart;           // start taken on the end beat
    vrf_cfg_pkg::grp_idx_t   lim_reg;
    vrf_cfg_pkg::vreg_off_t  lim_off;
    vrf_cfg_pkg::vreg_addr_t cur_base;
    vrf_cfg_pkg::grp_idx_t   cur_reg, cur_max_reg;
    vrf_cfg_pkg::vreg_off_t  cur_off, cur_max_off;
    logic                    cur_widen;
    logic                    cur_turn;
    logic                    last;              // terminal count on the presented beat
    logic                    advance;           // element done, move on
    logic                    off_wrap;
    vrf_cfg_pkg::grp_idx_t   next_reg;
    vrf_cfg_pkg::vreg_off_t  next_off;

    assign busy    = (state == agu_pkg::AGU_BUSY);
    assign launch  = en & ~busy;

    // group limits for a new walk
    assign lim_reg = whole_reg ? vrf_cfg_pkg::grp_idx_t'((4'd1 << lmul) - 4'd1) : max_reg_in;
    assign lim_off = whole_reg ? vrf_cfg_pkg::vreg_off_t'(vrf_cfg_pkg::OFFS_PER_REG - 1)
                               : max_off_in;

    // launch from idle puts the first beat out in the same cycle
    always_comb begin
        if (launch) begin
            cur_base    = base_in;
            cur_reg     = '0;
            cur_off     = '0;
            cur_max_reg = lim_reg;
            cur_max_off = lim_off;
            cur_widen   = widen;
            cur_turn    = 1'b0;
        end else begin
            cur_base    = base_q;
            cur_reg     = reg_q;
            cur_off     = off_q;
            cur_max_reg = max_reg_q;
            cur_max_off = max_off_q;
            cur_widen   = widen_q;
            cur_turn    = turn_q;
        end
    end

    assign beat        = launch | busy;
    assign last        = (cur_reg == cur_max_reg) & (cur_off == cur_max_off) &
                         (~cur_widen | cur_turn);
    assign end_pulse   = beat & last;
    assign restart     = en & busy & last;      // back to back, no gap
    assign start_pulse = launch | restart_q;
    assign first_turn  = beat & ~cur_turn;
    assign idle        = ~busy;

    assign addr = cur_base + vrf_cfg_pkg::vreg_addr_t'(cur_reg); // wraps past reg 31
    assign off  = cur_off;

    // widening holds the element for one extra beat
    assign advance  = ~(cur_widen & ~cur_turn);
    assign off_wrap = (cur_off == cur_max_off);
    assign next_off = !advance ? cur_off :
                      off_wrap ? '0 : vrf_cfg_pkg::vreg_off_t'(cur_off + 3'd1);
    assign next_reg = (advance & off_wrap) ? vrf_cfg_pkg::grp_idx_t'(cur_reg + 3'd1) : cur_reg;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= agu_pkg::AGU_IDLE;
            base_q    <= '0;
            reg_q     <= '0;
            off_q     <= '0;
            max_reg_q <= '0;
            max_off_q <= '0;
            widen_q   <= 1'b0;
            turn_q    <= 1'b0;
            restart_q <= 1'b0;
        end else begin
            restart_q <= restart;
            if (restart) begin
                // end beat goes out now, new walk starts at index 0 next cycle
                state     <= agu_pkg::AGU_BUSY;
                base_q    <= base_in;
                reg_q     <= '0;
                off_q     <= '0;
                max_reg_q <= lim_reg;
                max_off_q <= lim_off;
                widen_q   <= widen;
                turn_q    <= 1'b0;
            end else if (beat && !last) begin
                state     <= agu_pkg::AGU_BUSY;
                base_q    <= cur_base;      // latched on launch, held after
                reg_q     <= next_reg;
                off_q     <= next_off;
                max_reg_q <= cur_max_reg;
                max_off_q <= cur_max_off;
                widen_q   <= cur_widen;
                turn_q    <= cur_widen & ~cur_turn;
            end else if (beat) begin
                state     <= agu_pkg::AGU_IDLE; // walk done
                turn_q    <= 1'b0;
            end
        end
    end

endmodule

/* verilog/vreg_bank.sv */
`timescale 1ns/1ps

// vector register storage, one word per (register, offset)
module vreg_bank (
    input  logic                    clk,
    input  logic                    reset,
    // write beats from the write generator
    input  logic                    wr_beat,
    input  logic                    wr_first,   // first turn of a widened element
    input  vrf_cfg_pkg::vreg_addr_t wr_addr,
    input  vrf_cfg_pkg::vreg_off_t  wr_off,
    input  vrf_cfg_pkg::vdata_t     wr_data,
    // read beats from the read generator
    input  logic                    rd_beat,
    input  vrf_cfg_pkg::vreg_addr_t rd_addr,
    input  vrf_cfg_pkg::vreg_off_t  rd_off,
    output vrf_cfg_pkg::vdata_t     rd_data,    // one cycle after the read beat
    output logic                    rd_valid
);

    // 32 registers x 8 words
    vrf_cfg_pkg::vdata_t    mem [vrf_cfg_pkg::BANK_WORDS];

    vrf_cfg_pkg::bank_idx_t wr_idx;
    vrf_cfg_pkg::bank_idx_t rd_idx;
    logic                   wr_take;

    // register address selects the 8-word block, offset picks the word
    assign wr_idx  = {wr_addr, wr_off};
    assign rd_idx  = {rd_addr, rd_off};

    // a widened element is written once, on its first turn
    assign wr_take = wr_beat & wr_first;

    // write port
    always_ff @(posedge clk) begin
        if (wr_take) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // registered read port
    // a write to the same word on this edge is not seen, old data comes out
    always_ff @(posedge clk) begin
        if (rd_beat) begin
            rd_data <= mem[rd_idx];
        end
    end

    // valid tracks every read beat, repeats on widened beats
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_beat;
        end
    end

endmodule

/* verilog/vrf_subsystem.sv */
`timescale 1ns/1ps

// element-address side of the vector register file
module vrf_subsystem (
    input  logic                    clk,
    input  logic                    reset,
    // write side command
    input  logic                    wr_en,
    input  vrf_cfg_pkg::vreg_addr_t wr_base,
    input  vrf_cfg_pkg::grp_idx_t   wr_max_reg,
    input  vrf_cfg_pkg::vreg_off_t  wr_max_off,
    input  logic                    wr_whole,
    input  agu_pkg::lmul_code_t     wr_lmul,
    input  logic                    wr_widen,
    input  vrf_cfg_pkg::vdata_t     wr_data,    // presented on every write beat
    // read side command
    input  logic                    rd_en,
    input  vrf_cfg_pkg::vreg_addr_t rd_base,
    input  vrf_cfg_pkg::grp_idx_t   rd_max_reg,
    input  vrf_cfg_pkg::vreg_off_t  rd_max_off,
    input  logic                    rd_whole,
    input  agu_pkg::lmul_code_t     rd_lmul,
    input  logic                    rd_widen,
    // write side status
    output vrf_cfg_pkg::vreg_addr_t wr_addr,
    output vrf_cfg_pkg::vreg_off_t  wr_off,
    output logic                    wr_beat,
    output logic                    wr_start,
    output logic                    wr_end,
    output logic                    wr_idle,
    // read side status and data
    output vrf_cfg_pkg::vreg_addr_t rd_addr,
    output vrf_cfg_pkg::vreg_off_t  rd_off,
    output logic                    rd_beat,
    output logic                    rd_start,
    output logic                    rd_end,
    output logic                    rd_idle,
    output vrf_cfg_pkg::vdata_t     rd_data,
    output logic                    rd_valid
);

    logic wr_first;     // write once per widened element

    addr_gen_unit u_wr_agu (
        .clk         (clk),
        .reset       (reset),
        .en          (wr_en),
        .whole_reg   (wr_whole),
        .widen       (wr_widen),
        .lmul        (wr_lmul),
        .base_in     (wr_base),
        .max_reg_in  (wr_max_reg),
        .max_off_in  (wr_max_off),
        .addr        (wr_addr),
        .off         (wr_off),
        .beat        (wr_beat),
        .first_turn  (wr_first),
        .start_pulse (wr_start),
        .end_pulse   (wr_end),
        .idle        (wr_idle)
    );

    // read side repeats widened words, every beat reads
    addr_gen_unit u_rd_agu (
        .clk         (clk),
        .reset       (reset),
        .en          (rd_en),
        .whole_reg   (rd_whole),
        .widen       (rd_widen),
        .lmul        (rd_lmul),
        .base_in     (rd_base),
        .max_reg_in  (rd_max_reg),
        .max_off_in  (rd_max_off),
        .addr        (rd_addr),
        .off         (rd_off),
        .beat        (rd_beat),
        .first_turn  (),
        .start_pulse (rd_start),
        .end_pulse   (rd_end),
        .idle        (rd_idle)
    );

    vreg_bank u_bank (
        .clk      (clk),
        .reset    (reset),
        .wr_beat  (wr_beat),
        .wr_first (wr_first),
        .wr_addr  (wr_addr),
        .wr_off   (wr_off),
        .wr_data  (wr_data),
        .rd_beat  (rd_beat),
        .rd_addr  (rd_addr),
        .rd_off   (rd_off),
        .rd_data  (rd_data),    // trails rd_beat by one cycle
        .rd_valid (rd_valid)
    );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

// clock and reset source for the testbench
module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);  // held for two rising edges
        reset <= 1'b0;
    end

endmodule

/* sim/vrf_tb.sv */
`timescale 1ns/1ps

module vrf_tb;

    logic clk, reset;
    logic wr_en, wr_whole, wr_widen, rd_en, rd_whole, rd_widen;
    vrf_cfg_pkg::vreg_addr_t wr_base, rd_base, wr_addr, rd_addr;
    vrf_cfg_pkg::grp_idx_t   wr_max_reg, rd_max_reg;
    vrf_cfg_pkg::vreg_off_t  wr_max_off, rd_max_off, wr_off, rd_off;
    agu_pkg::lmul_code_t     wr_lmul, rd_lmul;
    vrf_cfg_pkg::vdata_t     wr_data, rd_data;
    logic wr_beat, wr_start, wr_end, wr_idle;
    logic rd_beat, rd_start, rd_end, rd_idle, rd_valid;

    // command table columns side base last_reg last_off whole lmul widen count mode
    int c_side[64], c_base[64], c_mreg[64], c_moff[64], c_whole[64];
    int c_lmul[64], c_widen[64], c_cnt[64], c_mode[64];
    int num_cmds;
    int cycles;
    int limit;                              // 0 until the file is loaded
    vrf_cfg_pkg::vdata_t shadow[256];       // model of the bank
    vrf_cfg_pkg::vdata_t pend_data;         // read word due one cycle later
    logic pend_valid;
    logic [31:0] lfsr_q;

    tb_clock u_clock (.clk(clk), .reset(reset));

    vrf_subsystem dut_i (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("Checks failed");
            $fatal(1, "timeout: the run went past %0d cycles", limit);
        end
    end

    // taps 32,22,2,1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic gen_word(output vrf_cfg_pkg::vdata_t w);
        for (int b = 0; b < vrf_cfg_pkg::DATA_WIDTH; b++) begin
            lfsr_q = lfsr_next(lfsr_q); // one step per bit
            w[b]   = lfsr_q[0];
        end
    endtask

    task automatic report_error(input string what);
        $display("Checks failed");
        $fatal(1, "%s", what);
    endtask

    task automatic check_addr(input string name, input vrf_cfg_pkg::vreg_addr_t exp,
                              input vrf_cfg_pkg::vreg_addr_t act);
        if (exp !== act) begin
            $display("FAIL %s addr expected %0d actual %0d", name, exp, act);
            report_error("register address mismatch");
        end
    endtask

    task automatic check_off(input string name, input vrf_cfg_pkg::vreg_off_t exp,
                             input vrf_cfg_pkg::vreg_off_t act);
        if (exp !== act) begin
            $display("FAIL %s off expected %0d actual %0d", name, exp, act);
            report_error("offset mismatch");
        end
    endtask

    task automatic check_data(input string name, input vrf_cfg_pkg::vdata_t exp,
                              input vrf_cfg_pkg::vdata_t act);
        if (exp !== act) begin
            $display("FAIL %s rd_data expected %h actual %h", name, exp, act);
            report_error("read data mismatch");
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("FAIL %s beats expected %0d actual %0d", name, exp, act);
            report_error("beat count mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAIL %s expected %b actual %b", name, exp, act);
            report_error("control flag mismatch");
        end
    endtask

    // put command j on its side's inputs and optionally disturb the base
    task automatic drive_cmd(input int j, input logic en_v, input logic flip);
        vrf_cfg_pkg::vreg_addr_t b;
        b = vrf_cfg_pkg::vreg_addr_t'(c_base[j]) ^ (flip ? 5'h1f : 5'h00);
        if (c_side[j] == 0) begin
            wr_en      <= en_v;
            wr_base    <= b;
            wr_max_reg <= vrf_cfg_pkg::grp_idx_t'(c_mreg[j]);
            wr_max_off <= vrf_cfg_pkg::vreg_off_t'(c_moff[j]);
            wr_whole   <= c_whole[j][0];
            wr_lmul    <= agu_pkg::lmul_code_t'(c_lmul[j]);
            wr_widen   <= c_widen[j][0];
        end else begin
            rd_en      <= en_v;
            rd_base    <= b;
            rd_max_reg <= vrf_cfg_pkg::grp_idx_t'(c_mreg[j]);
            rd_max_off <= vrf_cfg_pkg::vreg_off_t'(c_moff[j]);
            rd_whole   <= c_whole[j][0];
            rd_lmul    <= agu_pkg::lmul_code_t'(c_lmul[j]);
            rd_widen   <= c_widen[j][0];
        end
    endtask

    task automatic check_pending(input string name);
        if (pend_valid) begin
            check_flag({name, " rd_valid"}, 1'b1, rd_valid);
            check_data(name, pend_data, rd_data);
        end
        pend_valid = 1'b0;
    endtask

    task automatic run_walk(input int i);
        int side, lr, lo, per, n, k, e, idx;
        logic done, chain_in, chain_out;
        logic bt, st, en_o, idl;
        vrf_cfg_pkg::vreg_addr_t a;
        vrf_cfg_pkg::vreg_off_t o;
        vrf_cfg_pkg::vdata_t w;
        string name;
        name      = $sformatf("cmd%0d", i);
        side      = c_side[i];
        lr        = c_whole[i] != 0 ? (1 << c_lmul[i]) - 1 : c_mreg[i]; // group limits
        lo        = c_whole[i] != 0 ? 7 : c_moff[i];
        per       = c_widen[i] != 0 ? 2 : 1;
        n         = (lr + 1) * (lo + 1) * per;
        chain_in  = (c_mode[i] == 1);
        chain_out = (i + 1 < num_cmds) && (c_mode[i + 1] == 1);
        if (!chain_in) begin
            while (!(side == 0 ? wr_idle : rd_idle)) @(negedge clk);
        end
        k    = 0;
        done = 1'b0;
        while (!done && k <= c_cnt[i]) begin   // stops one beat past the file count
            @(posedge clk);
            if (k == 0 && !chain_in) drive_cmd(i, 1'b1, 1'b0);
            else if (side == 0) wr_en <= 1'b0;
            else rd_en <= 1'b0;
            if (c_mode[i] == 2 && k == n / 2) drive_cmd(i, 1'b1, 1'b1); // ignored mid-walk
            if (c_mode[i] == 2 && k == n / 2 + 1) drive_cmd(i, 1'b0, 1'b0);
            if (chain_out && k == n - 1) drive_cmd(i + 1, 1'b1, 1'b0); // on the end beat
            gen_word(w);
            if (side == 0) wr_data <= w;
            @(negedge clk);
            bt   = side == 0 ? wr_beat : rd_beat;
            a    = side == 0 ? wr_addr : rd_addr;
            o    = side == 0 ? wr_off : rd_off;
            st   = side == 0 ? wr_start : rd_start;
            en_o = side == 0 ? wr_end : rd_end;
            idl  = side == 0 ? wr_idle : rd_idle;
            if (!bt) report_error($sformatf("%s: beat dropped before the end pulse", name));
            if (side == 1) check_pending(name);
            e   = k / per;
            idx = ((c_base[i] + e / (lo + 1)) % 32) * 8 + e % (lo + 1);
            check_addr(name, vrf_cfg_pkg::vreg_addr_t'(idx / 8), a);
            check_off(name, vrf_cfg_pkg::vreg_off_t'(idx % 8), o);
            check_flag({name, " start"}, k == 0, st);
            check_flag({name, " idle"}, k == 0 && !chain_in, idl); // low once busy
            if (side == 0 && (per == 1 || k % 2 == 0)) shadow[idx] = w; // first turn only
            if (side == 1) begin
                pend_data  = shadow[idx];
                pend_valid = 1'b1;
            end
            done = en_o;
            k++;
        end
        if (side == 1 && !chain_out) begin
            @(negedge clk);
            check_pending(name);    // last word trails the end beat
        end
        check_count(name, c_cnt[i], k);
    endtask

    initial begin
        int fd, cnt, total;
        string line;
        wr_en      = 1'b0;
        wr_base    = '0;
        wr_max_reg = '0;
        wr_max_off = '0;
        wr_whole   = 1'b0;
        wr_lmul    = '0;
        wr_widen   = 1'b0;
        wr_data    = '0;
        rd_en      = 1'b0;
        rd_base    = '0;
        rd_max_reg = '0;
        rd_max_off = '0;
        rd_whole   = 1'b0;
        rd_lmul    = '0;
        rd_widen   = 1'b0;
        cycles     = 0;
        limit      = 0;
        pend_valid = 1'b0;
        lfsr_q     = 32'he2d8f757;
        num_cmds   = 0;
        total      = 0;
        fd = $fopen("sim/vrf_input.txt", "r");
        if (fd == 0) report_error("cannot open sim/vrf_input.txt");
        while (!$feof(fd)) begin
            cnt = $fgets(line, fd);
            if (cnt > 1 && line[0] != "#") begin
                cnt = $sscanf(line, "%d %d %d %d %d %d %d %d %d", c_side[num_cmds],
                              c_base[num_cmds], c_mreg[num_cmds], c_moff[num_cmds],
                              c_whole[num_cmds], c_lmul[num_cmds], c_widen[num_cmds],
                              c_cnt[num_cmds], c_mode[num_cmds]);
                if (cnt == 9) begin
                    total += c_cnt[num_cmds];
                    num_cmds++;
                end
            end
        end
        $fclose(fd);
        limit = total + 50;
        @(negedge clk);
        while (reset) @(negedge clk);
        check_flag("reset wr_beat", 1'b0, wr_beat);
        check_flag("reset rd_beat", 1'b0, rd_beat);
        check_flag("reset rd_valid", 1'b0, rd_valid);
        check_flag("reset wr_idle", 1'b1, wr_idle);
        check_flag("reset rd_idle", 1'b1, rd_idle);
        for (int i = 0; i < num_cmds; i++) run_walk(i);
        $display("All checks passed");
        $finish;
    end

endmodule

/* sim/vrf_input.txt */
# side(0 wr,1 rd) base last_reg last_off whole lmul widen beats mode
# mode: 0 start when idle, 1 start on the end beat of the line before, 2 extra start mid-walk
0 0 1 3 0 0 0 8 0
1 0 1 3 0 0 0 8 0
0 2 0 7 1 0 0 8 0
0 4 0 0 1 1 0 16 0
0 8 0 0 1 2 0 32 0
0 28 0 0 1 3 0 64 0
1 28 0 0 1 3 0 64 0
0 12 1 2 0 0 1 12 0
1 12 1 2 0 0 1 12 0
1 12 1 2 0 0 0 6 0
0 16 0 3 0 0 0 4 0
0 17 0 3 0 0 0 4 1
1 16 1 3 0 0 0 8 0
0 20 2 1 0 0 0 6 2
1 20 2 1 0 0 0 6 0
1 4 1 7 0 0 0 16 0
1 8 0 7 0 0 0 8 1

/* tb.f */
verilog/vrf_cfg_pkg.sv
verilog/agu_pkg.sv
verilog/addr_gen_unit.sv
verilog/vreg_bank.sv
verilog/vrf_subsystem.sv
sim/tb_clock.sv
sim/vrf_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run from the project root; a $fatal gives a non-zero status
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module vrf_tb -f tb.f -o vrf_sim &&
./obj_dir/vrf_sim || exit 1
